// ==== include/umi_consts.svh ====
`ifndef UMI_CONSTS_SVH
`define UMI_CONSTS_SVH

// Bus widths
`define UMI_AW          64
`define UMI_IDW         64
// Needs at least twice UMI_IDW
`define UMI_ODW         128

// Opcode codes
`define UMI_OP_READ     5'h01
`define UMI_OP_WRRESP   5'h02
`define UMI_OP_WRITE    5'h03
`define UMI_OP_POSTED   5'h05
`define UMI_OP_RDMA     5'h07
`define UMI_OP_RDRESP   5'h08
`define UMI_OP_ATOMIC   5'h09

// Finished wide packets held at the output
`define UMI_QDEPTH      2

`endif

// ==== src/umi_pkg.sv ====
`include "umi_consts.svh"

package umi_pkg;

    // Decoded command, one field per UMI command field
    typedef struct packed {
        logic [4:0]     opcode;
        logic [2:0]     size;
        logic [7:0]     len;
        logic [7:0]     atype;
        logic [3:0]     qos;
        logic [1:0]     prot;
        logic           eom;
        logic           eof;
        logic           ex;
        logic [1:0]     user;
        logic [23:0]    user_ext;
        logic [1:0]     err;
        logic [4:0]     hostid;
    } umi_cmd_t;

    typedef struct packed {
        umi_cmd_t               cmd;
        logic [`UMI_AW-1:0]     dstaddr;
        logic [`UMI_AW-1:0]     srcaddr;
        logic [`UMI_IDW-1:0]    data;
    } umi_in_pkt_t;

    typedef struct packed {
        umi_cmd_t               cmd;
        logic [`UMI_AW-1:0]     dstaddr;
        logic [`UMI_AW-1:0]     srcaddr;
        logic [`UMI_ODW-1:0]    data;
    } umi_out_pkt_t;

    // Packet plus what the stage worked out about it
    typedef struct packed {
        umi_in_pkt_t                    pkt;
        logic [$clog2(`UMI_IDW/8):0]    bytes;
        logic                           mergeable;
    } umi_staged_t;

endpackage

// ==== src/umi_in_stage.sv ====
`timescale 1ns/1ps
`include "umi_consts.svh"

module umi_in_stage (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    in_valid,
    input  umi_pkg::umi_in_pkt_t    in_pkt,
    output logic                    in_ready,
    output logic                    stg_valid,
    output umi_pkg::umi_staged_t    stg,
    input  logic                    stg_ready
);

    localparam int BFW = 17;

    logic                   accept;
    logic                   prev_valid;
    umi_pkg::umi_cmd_t      prev_cmd;
    logic [`UMI_AW-1:0]     next_dst;
    logic [`UMI_AW-1:0]     next_src;
    logic [BFW-1:0]         bytes_full;
    logic                   op_ok;
    logic                   fields_ok;
    logic                   addr_ok;

    // Fields allowed to differ within a group are cleared before the compare
    function automatic umi_pkg::umi_cmd_t merge_key(input umi_pkg::umi_cmd_t c);
        umi_pkg::umi_cmd_t k;
        k          = c;
        k.len      = '0;
        k.atype    = '0;
        k.user_ext = '0;
        k.eom      = 1'b0;
        return k;
    endfunction

    assign accept   = in_valid & in_ready;
    assign in_ready = ~stg_valid | stg_ready;

    // Word bytes times word count
    assign bytes_full = (BFW'(1) << in_pkt.cmd.size) * (BFW'(in_pkt.cmd.len) + BFW'(1));

    assign op_ok = in_pkt.cmd.opcode inside {`UMI_OP_READ, `UMI_OP_WRITE, `UMI_OP_POSTED,
                                             `UMI_OP_RDMA, `UMI_OP_RDRESP, `UMI_OP_WRRESP};

    assign fields_ok = (merge_key(in_pkt.cmd) == merge_key(prev_cmd));

    assign addr_ok = (in_pkt.dstaddr == next_dst) & (in_pkt.srcaddr == next_src);

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            stg_valid  <= 1'b0;
            prev_valid <= 1'b0;
        end
        else if (accept) begin
            stg_valid  <= 1'b1;
            prev_valid <= 1'b1;
        end
        else if (stg_ready) begin
            stg_valid  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stg.pkt       <= in_pkt;
            stg.bytes     <= bytes_full[$bits(stg.bytes)-1:0];
            stg.mergeable <= prev_valid & op_ok & fields_ok & addr_ok & ~in_pkt.cmd.ex;
            prev_cmd      <= in_pkt.cmd;
            // Where a continuation of this packet has to start
            next_dst      <= in_pkt.dstaddr + {{(`UMI_AW-BFW){1'b0}}, bytes_full};
            next_src      <= in_pkt.srcaddr + {{(`UMI_AW-BFW){1'b0}}, bytes_full};
        end
    end

    // A narrow packet never carries more than one input data word
    a_bytes_fit: assert property (
        @(posedge clk) disable iff (!nreset)
        accept |-> (bytes_full <= BFW'(`UMI_IDW/8))
    );

endmodule

// ==== src/umi_merge_acc.sv ====
`timescale 1ns/1ps
`include "umi_consts.svh"

module umi_merge_acc (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    stg_valid,
    input  umi_pkg::umi_staged_t    stg,
    output logic                    stg_ready,
    output logic                    acc_valid,
    output umi_pkg::umi_out_pkt_t   acc_pkt,
    input  logic                    acc_ready
);

    localparam int OBYTES = `UMI_ODW / 8;
    localparam int CNTW   = $clog2(OBYTES) + 1;

    logic [CNTW-1:0]        byte_cnt;
    logic [CNTW:0]          byte_sum;
    logic                   done_r;
    logic                   open;
    logic                   joins;
    logic                   consume;
    logic                   handoff;
    logic                   fresh;
    logic [`UMI_ODW-1:0]    mask;
    logic [`UMI_ODW-1:0]    data_in;
    logic [`UMI_ODW-1:0]    data_r;
    umi_pkg::umi_cmd_t      cmd_r;
    logic [`UMI_AW-1:0]     dst_r;
    logic [`UMI_AW-1:0]     src_r;
    logic [7:0]             len_out;

    assign open     = (byte_cnt != '0);
    assign byte_sum = {1'b0, byte_cnt} + (CNTW+1)'(stg.bytes);
    assign joins    = stg.mergeable & (byte_sum <= (CNTW+1)'(OBYTES));

    // Closed by eom earlier, or a staged packet that cannot join
    assign acc_valid = done_r | (stg_valid & open & ~joins);
    assign stg_ready = ~acc_valid | acc_ready;

    assign consume = stg_valid & stg_ready;
    assign handoff = acc_valid & acc_ready;
    assign fresh   = ~open | handoff;

    // Only the valid bytes of the narrow word
    assign mask    = ~({`UMI_ODW{1'b1}} << {stg.bytes, 3'b000});
    assign data_in = {{(`UMI_ODW-`UMI_IDW){1'b0}}, stg.pkt.data} & mask;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            byte_cnt <= '0;
            done_r   <= 1'b0;
        end
        else if (consume) begin
            byte_cnt <= fresh ? CNTW'(stg.bytes) : byte_sum[CNTW-1:0];
            done_r   <= stg.pkt.cmd.eom;
        end
        else if (handoff) begin
            byte_cnt <= '0;
            done_r   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (consume) begin
            if (fresh) begin
                data_r <= data_in;
                cmd_r  <= stg.pkt.cmd;
                dst_r  <= stg.pkt.dstaddr;
                src_r  <= stg.pkt.srcaddr;
            end
            else begin
                // Append above the bytes already held
                data_r    <= data_r | (data_in << {byte_cnt, 3'b000});
                cmd_r.eom <= stg.pkt.cmd.eom;
            end
        end
    end

    assign len_out = 8'(byte_cnt >> cmd_r.size) - 8'd1;

    always_comb begin
        acc_pkt         = '0;
        acc_pkt.cmd     = cmd_r;
        acc_pkt.cmd.len = len_out;
        acc_pkt.dstaddr = dst_r;
        acc_pkt.srcaddr = src_r;
        acc_pkt.data    = data_r;
    end

    a_cnt_range: assert property (
        @(posedge clk) disable iff (!nreset)
        byte_cnt <= CNTW'(OBYTES)
    );

    // Offered wide packet must not change until taken
    a_out_stable: assert property (
        @(posedge clk) disable iff (!nreset)
        (acc_valid & ~acc_ready) |=> (acc_valid & $stable(acc_pkt))
    );

endmodule

// ==== src/umi_out_queue.sv ====
`timescale 1ns/1ps
`include "umi_consts.svh"

module umi_out_queue (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    acc_valid,
    input  umi_pkg::umi_out_pkt_t   acc_pkt,
    output logic                    acc_ready,
    output logic                    out_valid,
    output umi_pkg::umi_out_pkt_t   out_pkt,
    input  logic                    out_ready
);

    localparam int PW = (`UMI_QDEPTH > 1) ? $clog2(`UMI_QDEPTH) : 1;

    umi_pkg::umi_out_pkt_t  mem [`UMI_QDEPTH];
    logic [PW-1:0]          wr_ptr;
    logic [PW-1:0]          rd_ptr;
    logic [PW:0]            count;
    logic                   wr_en;
    logic                   rd_en;

    // Circular pointer step
    function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
        return (p == PW'(`UMI_QDEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign acc_ready = (count != (PW+1)'(`UMI_QDEPTH));
    assign out_valid = (count != '0);
    assign out_pkt   = mem[rd_ptr];

    assign wr_en = acc_valid & acc_ready;
    assign rd_en = out_valid & out_ready;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (wr_en)
                wr_ptr <= ptr_next(wr_ptr);
            if (rd_en)
                rd_ptr <= ptr_next(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= acc_pkt;
    end

    // A write never lands on an entry still waiting to be read
    a_no_overwrite: assert property (
        @(posedge clk) disable iff (!nreset)
        wr_en |-> ((wr_ptr != rd_ptr) || (count == '0))
    );

endmodule

// ==== src/umi_merge_top.sv ====
`timescale 1ns/1ps

module umi_merge_top (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    in_valid,
    input  umi_pkg::umi_in_pkt_t    in_pkt,
    output logic                    in_ready,
    output logic                    out_valid,
    output umi_pkg::umi_out_pkt_t   out_pkt,
    input  logic                    out_ready
);

    logic                   stg_valid;
    umi_pkg::umi_staged_t   stg;
    logic                   stg_ready;
    logic                   acc_valid;
    umi_pkg::umi_out_pkt_t  acc_pkt;
    logic                   acc_ready;

    umi_in_stage i_umi_in_stage (
        .clk        (clk),
        .nreset     (nreset),
        .in_valid   (in_valid),
        .in_pkt     (in_pkt),
        .in_ready   (in_ready),
        .stg_valid  (stg_valid),
        .stg        (stg),
        .stg_ready  (stg_ready)
    );

    umi_merge_acc i_umi_merge_acc (
        .clk        (clk),
        .nreset     (nreset),
        .stg_valid  (stg_valid),
        .stg        (stg),
        .stg_ready  (stg_ready),
        .acc_valid  (acc_valid),
        .acc_pkt    (acc_pkt),
        .acc_ready  (acc_ready)
    );

    umi_out_queue i_umi_out_queue (
        .clk        (clk),
        .nreset     (nreset),
        .acc_valid  (acc_valid),
        .acc_pkt    (acc_pkt),
        .acc_ready  (acc_ready),
        .out_valid  (out_valid),
        .out_pkt    (out_pkt),
        .out_ready  (out_ready)
    );

endmodule

// ==== verification/umi_merge_tb.sv ====
`timescale 1ns/1ps
`include "umi_consts.svh"

module umi_merge_tb;

    // Packets over all tests, used to size the watchdog
    localparam int     TOTAL_PKTS = 57;
    localparam longint WD_NS      = longint'(TOTAL_PKTS * 20 + 16) * 100;

    logic                   clk;
    logic                   nreset;
    logic                   in_valid;
    umi_pkg::umi_in_pkt_t   in_pkt;
    logic                   in_ready;
    logic                   out_valid;
    umi_pkg::umi_out_pkt_t  out_pkt;
    logic                   out_ready;
    logic                   rand_ready;
    logic [15:0]            lfsr_state;
    umi_pkg::umi_in_pkt_t   in_q[$];
    umi_pkg::umi_out_pkt_t  exp_q[$];
    int                     n_checks;
    int                     n_errors;
    int                     n_tests;
    int                     n_failed;
    int                     n_outputs;

    umi_merge_top i_umi_merge_top (
        .clk        (clk),
        .nreset     (nreset),
        .in_valid   (in_valid),
        .in_pkt     (in_pkt),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_pkt    (out_pkt),
        .out_ready  (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int k = 0; k < n; k++)
            r = {r[62:0], next_rand_bit()};
        return r;
    endfunction

    function automatic int pkt_bytes(input umi_pkg::umi_cmd_t c);
        return (1 << c.size) * (int'(c.len) + 1);
    endfunction

    function automatic umi_pkg::umi_in_pkt_t make_pkt(input logic [4:0] op, input logic [2:0] sz,
            input logic [7:0] ln, input logic [63:0] addr, input logic [63:0] data,
            input logic eom);
        umi_pkg::umi_in_pkt_t p;
        p            = '0;
        p.cmd.opcode = op;
        p.cmd.size   = sz;
        p.cmd.len    = ln;
        p.cmd.eom    = eom;
        p.cmd.hostid = 5'h3;
        p.dstaddr    = addr;
        p.srcaddr    = addr + 64'h1000_0000;
        p.data       = data;
        return p;
    endfunction

    // Continuation of prev under the merge rules, byte limit aside
    function automatic logic mergeable(input umi_pkg::umi_in_pkt_t p,
            input umi_pkg::umi_in_pkt_t prev);
        logic op_ok;
        logic same;
        op_ok = (p.cmd.opcode == `UMI_OP_READ) || (p.cmd.opcode == `UMI_OP_WRITE) ||
                (p.cmd.opcode == `UMI_OP_POSTED) || (p.cmd.opcode == `UMI_OP_RDMA) ||
                (p.cmd.opcode == `UMI_OP_RDRESP) || (p.cmd.opcode == `UMI_OP_WRRESP);
        same  = (p.cmd.opcode == prev.cmd.opcode) && (p.cmd.size == prev.cmd.size) &&
                (p.cmd.qos == prev.cmd.qos) && (p.cmd.prot == prev.cmd.prot) &&
                (p.cmd.eof == prev.cmd.eof) && (p.cmd.ex == prev.cmd.ex) &&
                (p.cmd.user == prev.cmd.user) && (p.cmd.err == prev.cmd.err) &&
                (p.cmd.hostid == prev.cmd.hostid);
        return op_ok && same && !p.cmd.ex &&
               (p.dstaddr == prev.dstaddr + 64'(pkt_bytes(prev.cmd))) &&
               (p.srcaddr == prev.srcaddr + 64'(pkt_bytes(prev.cmd)));
    endfunction

    function automatic void push_group(input umi_pkg::umi_out_pkt_t g, input int nbytes);
        g.cmd.len = 8'((nbytes >> g.cmd.size) - 1);
        exp_q.push_back(g);
    endfunction

    // Expected wide packets for one test's input sequence
    function automatic void merge_ref(input umi_pkg::umi_in_pkt_t pkts[$]);
        umi_pkg::umi_out_pkt_t cur;
        int                    nbytes;
        int                    b;
        logic                  join_grp;
        logic [127:0]          d;
        cur    = '0;
        nbytes = 0;
        foreach (pkts[i]) begin
            b        = pkt_bytes(pkts[i].cmd);
            join_grp = (i > 0) && (nbytes > 0) && mergeable(pkts[i], pkts[i-1]) &&
                       (nbytes + b <= 16);
            if (nbytes > 0 && !join_grp) begin
                push_group(cur, nbytes);
                nbytes = 0;
            end
            d = 128'(pkts[i].data) & ((128'(1) << (8 * b)) - 128'(1));
            if (nbytes == 0) begin
                cur.cmd     = pkts[i].cmd;
                cur.dstaddr = pkts[i].dstaddr;
                cur.srcaddr = pkts[i].srcaddr;
                cur.data    = d;
            end
            else begin
                cur.data    = cur.data | (d << (8 * nbytes));
                cur.cmd.eom = pkts[i].cmd.eom;
            end
            nbytes = nbytes + b;
            if (pkts[i].cmd.eom) begin
                push_group(cur, nbytes);
                nbytes = 0;
            end
        end
    endfunction

    task automatic check_value(input string what, input logic [127:0] got, input logic [127:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_pkt(input string what, input umi_pkg::umi_out_pkt_t got,
            input umi_pkg::umi_out_pkt_t exp);
        check_value({what, " cmd"}, 128'(got.cmd), 128'(exp.cmd));
        check_value({what, " dstaddr"}, 128'(got.dstaddr), 128'(exp.dstaddr));
        check_value({what, " srcaddr"}, 128'(got.srcaddr), 128'(exp.srcaddr));
        check_value({what, " data"}, got.data, exp.data);
    endtask

    // Called 5 ns after a rising edge, returns at the same phase
    task automatic send_pkt(input umi_pkg::umi_in_pkt_t p);
        in_pkt   = p;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        @(posedge clk);
        #5;
        in_valid = 1'b0;
    endtask

    task automatic run_test(input string name);
        int errs0;
        errs0 = n_errors;
        merge_ref(in_q);
        foreach (in_q[i])
            send_pkt(in_q[i]);
        while (exp_q.size() != 0)
            @(negedge clk);
        // A few idle cycles so a surplus output gets caught here
        repeat (3) @(posedge clk);
        #5;
        n_tests++;
        if (n_errors != errs0)
            n_failed++;
        $display("test %0d %s: %0d packets in, %0d errors", n_tests, name, in_q.size(),
                 n_errors - errs0);
        in_q.delete();
    endtask

    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #5;
            out_ready = rand_ready ? next_rand_bit() : 1'b1;
        end
    end

    // Output transfers happen at the rising edge after this sample
    initial begin
        logic                  stall_seen;
        umi_pkg::umi_out_pkt_t held;
        stall_seen = 1'b0;
        held       = '0;
        forever begin
            @(negedge clk);
            if (nreset) begin
                if (stall_seen) begin
                    if (!out_valid) begin
                        n_errors++;
                        $display("ERROR at %0t: out_valid dropped while stalled", $time);
                    end
                    else
                        compare_pkt("stalled out_pkt", out_pkt, held);
                end
                stall_seen = out_valid && !out_ready;
                held       = out_pkt;
                if (out_valid && out_ready) begin
                    n_outputs++;
                    if (exp_q.size() == 0) begin
                        n_errors++;
                        $display("ERROR at %0t: output packet with none expected", $time);
                    end
                    else
                        compare_pkt("out_pkt", out_pkt, exp_q.pop_front());
                end
            end
        end
    end

    initial begin
        #(WD_NS);
        $display("ERROR: run did not finish within %0d ns", WD_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [63:0]          addr;
        umi_pkg::umi_in_pkt_t p;
        logic [2:0]           sz;
        logic [7:0]           ln;
        nreset     = 1'b0;
        in_valid   = 1'b0;
        in_pkt     = '0;
        rand_ready = 1'b0;
        lfsr_state = 16'd35;
        n_checks   = 0;
        n_errors   = 0;
        n_tests    = 0;
        n_failed   = 0;
        n_outputs  = 0;
        repeat (16) @(posedge clk);
        #5;
        nreset = 1'b1;
        @(posedge clk);
        #5;
        check_value("out_valid after reset", 128'(out_valid), 128'(0));
        check_value("in_ready after reset", 128'(in_ready), 128'(1));

        in_q.push_back(make_pkt(`UMI_OP_WRITE, 3'd3, 8'd0, 64'h1000, 64'h0123_4567_89ab_cdef, 1'b1));
        run_test("single packet");

        in_q.push_back(make_pkt(`UMI_OP_WRITE, 3'd3, 8'd0, 64'h1100, 64'h1111_2222_3333_4444, 1'b0));
        in_q.push_back(make_pkt(`UMI_OP_WRITE, 3'd3, 8'd0, 64'h1108, 64'h5555_6666_7777_8888, 1'b1));
        run_test("two contiguous writes");

        // Each pair is broken by a gap, qos, ex or an atomic opcode
        // Ex and atomic go on both packets of their pair
        for (int k = 0; k < 4; k++) begin
            addr = 64'h100 * (k + 1);
            p = make_pkt(`UMI_OP_WRITE, 3'd3, 8'd0, addr, 64'hA0 + 64'(k), 1'b0);
            if (k == 2)
                p.cmd.ex = 1'b1;
            if (k == 3)
                p.cmd.opcode = `UMI_OP_ATOMIC;
            in_q.push_back(p);
            p = make_pkt(`UMI_OP_WRITE, 3'd3, 8'd0, addr + 64'h8, 64'hB0 + 64'(k), 1'b1);
            if (k == 0)
                p.dstaddr = p.dstaddr + 64'h10;
            if (k == 1)
                p.cmd.qos = 4'h1;
            if (k == 2)
                p.cmd.ex = 1'b1;
            if (k == 3)
                p.cmd.opcode = `UMI_OP_ATOMIC;
            in_q.push_back(p);
        end
        run_test("group breaks");

        in_q.push_back(make_pkt(`UMI_OP_WRITE, 3'd3, 8'd0, 64'h4000, 64'hC1C1_C1C1_C1C1_C1C1, 1'b0));
        in_q.push_back(make_pkt(`UMI_OP_WRITE, 3'd3, 8'd0, 64'h4008, 64'hC2C2_C2C2_C2C2_C2C2, 1'b0));
        in_q.push_back(make_pkt(`UMI_OP_WRITE, 3'd3, 8'd0, 64'h4010, 64'hC3C3_C3C3_C3C3_C3C3, 1'b1));
        in_q.push_back(make_pkt(`UMI_OP_POSTED, 3'd2, 8'd1, 64'h3000, 64'hD1D1_D1D1_D0D0_D0D0, 1'b0));
        in_q.push_back(make_pkt(`UMI_OP_POSTED, 3'd2, 8'd0, 64'h3008, 64'hFFFF_FFFF_D2D2_D2D2, 1'b0));
        in_q.push_back(make_pkt(`UMI_OP_POSTED, 3'd2, 8'd0, 64'h300C, 64'hEEEE_EEEE_D3D3_D3D3, 1'b1));
        run_test("overflow and mixed sizes");

        // Mostly contiguous, with an occasional gap, size change or eom
        addr = 64'h2000;
        for (int i = 0; i < 40; i++) begin
            if (rand_bits(3) == 64'd0)
                addr = addr + 64'h40;
            if (rand_bits(2) == 64'd0) begin
                sz = 3'd3;
                ln = 8'd0;
            end
            else begin
                sz = 3'd2;
                ln = 8'(rand_bits(1));
            end
            p = make_pkt(`UMI_OP_WRITE, sz, ln, addr, rand_bits(64),
                         (rand_bits(3) == 64'd0) || (i == 39));
            p.cmd.user_ext = 24'(rand_bits(8));
            in_q.push_back(p);
            addr = addr + 64'(pkt_bytes(p.cmd));
        end
        @(negedge clk);
        rand_ready = 1'b1;
        @(posedge clk);
        #5;
        run_test("random stream with back-pressure");

        $display("tests %0d, failed %0d, outputs %0d, checks %0d, errors %0d",
                 n_tests, n_failed, n_outputs, n_checks, n_errors);
        if (n_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
src/umi_pkg.sv
src/umi_in_stage.sv
src/umi_merge_acc.sv
src/umi_out_queue.sv
src/umi_merge_top.sv
verification/umi_merge_tb.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP        = umi_merge_tb
FLIST      = build.f
OBJDIR     = obj_dir
PASS_MSG   = PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)
